//--- turbo_dec_pkg.sv
`default_nettype none

package turbo_dec_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int llr_w    = 5;   // channel llr
  localparam int addr_w   = 8;   // bit address inside block
  localparam int lextr_w  = 6;   // extrinsic saturates here
  localparam int metric_w = 8;   // a-priori and a posteriori
  localparam int err_w    = 16;  // per block error counter

  // --------------------------------------------------
  // stage latencies in enabled cycles
  // --------------------------------------------------
  localparam int bmc_delay    = 1;
  localparam int lapo_delay   = 1;
  localparam int lextr_delay  = 1;
  localparam int engine_delay = bmc_delay + lapo_delay + lextr_delay;

  typedef logic signed [llr_w-1:0]    llr_t;
  typedef logic signed [lextr_w-1:0]  lextr_t;
  typedef logic signed [metric_w-1:0] metric_t;
  typedef logic        [addr_w-1:0]   addr_t;
  typedef logic        [err_w-1:0]    err_cnt_t;

endpackage

`default_nettype wire

//--- path_out_if.sv
`default_nettype none

// one path's extrinsic stage results
interface path_out_if;

  logic                  val;    // one beat per bit
  turbo_dec_pkg::lextr_t lextr;  // new extrinsic
  logic                  dat;    // hard decision
  logic                  err;    // decision vs channel hd

  modport src (
    output val, lextr, dat, err
  );

  modport snk (
    input  val, lextr, dat, err
  );

endinterface

`default_nettype wire

//--- turbo_dec_bmc.sv
`default_nettype none

module turbo_dec_bmc (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  logic                   val,
  input  logic                   first,       // first sub-iteration
  input  turbo_dec_pkg::llr_t    s_llr,       // systematic
  input  turbo_dec_pkg::llr_t    parity_llr,
  input  turbo_dec_pkg::lextr_t  lextr_in,    // extrinsic from other decoder
  output turbo_dec_pkg::metric_t lapri,
  output turbo_dec_pkg::metric_t gamma,
  output logic                   hd,
  output logic                   val_out
);

  // strobe pipe
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_out <= 1'b0;
    end else if (iclkena) begin
      val_out <= val;
    end
  end

  // payload regs
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // extrinsic is garbage on the first pass, treat as zero
      lapri <= turbo_dec_pkg::metric_t'(s_llr) +
               (first ? '0 : turbo_dec_pkg::metric_t'(lextr_in));
      gamma <= turbo_dec_pkg::metric_t'(parity_llr);  // sign extended
      hd    <= s_llr[turbo_dec_pkg::llr_w-1];         // negative llr -> 1
    end
  end

endmodule

`default_nettype wire

//--- turbo_dec_lextr.sv
`default_nettype none

module turbo_dec_lextr (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  logic                   val,
  input  turbo_dec_pkg::metric_t lapri,
  input  turbo_dec_pkg::metric_t gamma,
  input  logic                   sc_init,     // first pass, no history yet
  input  logic                   sc_ena,      // odd sub-iteration
  input  turbo_dec_pkg::lextr_t  lextr_prev,
  input  logic                   hd_chan,
  path_out_if.src                pout
);

  logic                   val_r;
  turbo_dec_pkg::metric_t lapo_r;
  turbo_dec_pkg::metric_t lapri_r;
  logic                   hd_r;
  logic                   sc_init_r;
  logic                   sc_ena_r;
  turbo_dec_pkg::lextr_t  lprev_r;

  logic signed [turbo_dec_pkg::metric_w+2:0] diff;    // lapo - lapri, wide
  logic signed [turbo_dec_pkg::metric_w+2:0] scaled;  // 3/4 of diff
  logic        [turbo_dec_pkg::metric_w+3-turbo_dec_pkg::lextr_w:0] upper;
  turbo_dec_pkg::lextr_t                     sat;
  turbo_dec_pkg::lextr_t                     lextr_nxt;

  // --------------------------------------------------
  // stage one, a posteriori sum
  // --------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_r    <= 1'b0;
      pout.val <= 1'b0;
    end else if (iclkena) begin
      val_r    <= val;
      pout.val <= val_r;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      lapo_r    <= lapri + gamma;  // no trellis, parity only
      lapri_r   <= lapri;
      hd_r      <= hd_chan;
      sc_init_r <= sc_init;
      sc_ena_r  <= sc_ena;
      lprev_r   <= lextr_prev;
    end
  end

  // --------------------------------------------------
  // stage two, scaled extrinsic
  // --------------------------------------------------
  always_comb begin
    diff   = lapo_r - lapri_r;
    scaled = ((diff <<< 1) + diff) >>> 2;  // floor(3*diff/4)
    upper  = scaled[turbo_dec_pkg::metric_w+2:turbo_dec_pkg::lextr_w-1];
    if ((&upper) || !(|upper)) begin
      sat = scaled[turbo_dec_pkg::lextr_w-1:0];  // fits
    end else begin
      sat = {upper[$high(upper)], {(turbo_dec_pkg::lextr_w-1){~upper[$high(upper)]}}};
    end
    // self-correction, drop values that flipped sign since last pass
    if (sc_ena_r && !sc_init_r && (lprev_r != '0) &&
        (sat[turbo_dec_pkg::lextr_w-1] != lprev_r[turbo_dec_pkg::lextr_w-1])) begin
      lextr_nxt = '0;
    end else begin
      lextr_nxt = sat;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      pout.lextr <= lextr_nxt;
      pout.dat   <= lapo_r[turbo_dec_pkg::metric_w-1];             // lapo < 0
      pout.err   <= lapo_r[turbo_dec_pkg::metric_w-1] ^ hd_r;      // channel disagrees
    end
  end

endmodule

`default_nettype wire

//--- turbo_dec_path.sv
`default_nettype none

module turbo_dec_path (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  iclkena,
  input  logic                  val,
  input  logic                  first,
  input  logic                  even,        // 1 = no permutation
  input  turbo_dec_pkg::llr_t   s_llr,
  input  turbo_dec_pkg::llr_t   parity_llr,
  input  turbo_dec_pkg::lextr_t lextr_in,
  path_out_if.src               pout
);

  logic                   bmc_val;
  turbo_dec_pkg::metric_t bmc_lapri;
  turbo_dec_pkg::metric_t bmc_gamma;
  logic                   bmc_hd;

  // sc controls, kept in step with bmc output
  logic                  first_d;
  logic                  even_d;
  turbo_dec_pkg::lextr_t lextr_d;

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      first_d <= first;
      even_d  <= even;
      lextr_d <= lextr_in;
    end
  end

  turbo_dec_bmc u_bmc (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .val        (val),
    .first      (first),
    .s_llr      (s_llr),
    .parity_llr (parity_llr),
    .lextr_in   (lextr_in),
    .lapri      (bmc_lapri),
    .gamma      (bmc_gamma),
    .hd         (bmc_hd),
    .val_out    (bmc_val)
  );

  turbo_dec_lextr u_lextr (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .val        (bmc_val),
    .lapri      (bmc_lapri),
    .gamma      (bmc_gamma),
    .sc_init    (first_d),
    .sc_ena     (!even_d),   // self-correction on odd passes only
    .lextr_prev (lextr_d),
    .hd_chan    (bmc_hd),
    .pout       (pout)
  );

endmodule

`default_nettype wire

//--- turbo_dec_ctrl_line.sv
`default_nettype none

module turbo_dec_ctrl_line (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  input  logic                 sop,
  input  logic                 eop,
  input  logic                 last,     // last sub-iteration
  input  logic                 fterm,    // forward termination bit
  input  logic                 bterm,    // backward termination bit
  input  turbo_dec_pkg::addr_t faddr,
  input  turbo_dec_pkg::addr_t baddr,
  output logic                 sop_d,
  output logic                 eop_d,
  output logic                 last_d,
  output logic                 fterm_d,
  output logic                 bterm_d,
  output turbo_dec_pkg::addr_t faddr_d,
  output turbo_dec_pkg::addr_t baddr_d
);

  // flags packed as {sop, eop, last, fterm, bterm}
  logic [4:0]           flag_sr  [turbo_dec_pkg::engine_delay];
  turbo_dec_pkg::addr_t faddr_sr [turbo_dec_pkg::engine_delay];
  turbo_dec_pkg::addr_t baddr_sr [turbo_dec_pkg::engine_delay];

  // --------------------------------------------------
  // shift line, same depth as the paths
  // --------------------------------------------------
  always_ff @(posedge iclk) begin
    if (iclkena && !ireset) begin  // held while in reset
      for (int i = 0; i < turbo_dec_pkg::engine_delay; i++) begin
        if (i == 0) begin
          flag_sr[i]  <= {sop, eop, last, fterm, bterm};
          faddr_sr[i] <= faddr;
          baddr_sr[i] <= baddr;
        end else begin
          flag_sr[i]  <= flag_sr[i-1];
          faddr_sr[i] <= faddr_sr[i-1];
          baddr_sr[i] <= baddr_sr[i-1];
        end
      end
    end
  end

  assign {sop_d, eop_d, last_d, fterm_d, bterm_d} = flag_sr[turbo_dec_pkg::engine_delay-1];
  assign faddr_d = faddr_sr[turbo_dec_pkg::engine_delay-1];
  assign baddr_d = baddr_sr[turbo_dec_pkg::engine_delay-1];

endmodule

`default_nettype wire

//--- turbo_dec_out.sv
`default_nettype none

module turbo_dec_out (
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    iclkena,
  path_out_if.snk                 f,
  path_out_if.snk                 b,
  input  logic                    sop_d,
  input  logic                    eop_d,
  input  logic                    last_d,
  input  logic                    fterm_d,
  input  logic                    bterm_d,
  output logic                    oval,
  output logic                    odone,
  output turbo_dec_pkg::err_cnt_t oerr,
  output turbo_dec_pkg::lextr_t   ofLextr,
  output logic                    ofdat,
  output turbo_dec_pkg::lextr_t   obLextr,
  output logic                    obdat
);

  logic f_add;  // counted forward error
  logic b_add;  // counted backward error

  // --------------------------------------------------
  // result mux
  // --------------------------------------------------
  assign oval    = f.val;  // both paths run in lock step
  assign ofLextr = f.lextr;
  assign ofdat   = f.dat;
  assign obLextr = b.lextr;
  assign obdat   = b.dat;

  // termination bits do not count
  assign f_add = f.val & f.err & ~fterm_d;
  assign b_add = b.val & b.err & ~bterm_d;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      odone <= 1'b0;
      oerr  <= '0;
    end else if (iclkena) begin
      odone <= oval & eop_d & last_d;  // end of final sub-iteration
      if (oval) begin
        // restart on block start, its own bit included
        oerr <= (sop_d ? '0 : oerr) + turbo_dec_pkg::err_cnt_t'(f_add)
                                    + turbo_dec_pkg::err_cnt_t'(b_add);
      end
    end
  end

endmodule

`default_nettype wire

//--- turbo_dec_engine.sv
`default_nettype none

module turbo_dec_engine (
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    iclkena,
  input  logic                    ifirst,   // first sub-iteration
  input  logic                    ilast,    // last sub-iteration
  input  logic                    ieven,    // 1 = no permutation
  input  logic                    isop,
  input  logic                    ival,
  input  logic                    ieop,
  input  logic                    ifterm,
  input  turbo_dec_pkg::addr_t    ifaddr,
  input  turbo_dec_pkg::llr_t     ifsLLR,
  input  turbo_dec_pkg::llr_t     ifa0LLR,
  input  turbo_dec_pkg::lextr_t   ifLextr,
  input  logic                    ibterm,
  input  turbo_dec_pkg::addr_t    ibaddr,
  input  turbo_dec_pkg::llr_t     ibsLLR,
  input  turbo_dec_pkg::llr_t     iba0LLR,
  input  turbo_dec_pkg::lextr_t   ibLextr,
  output logic                    osop,
  output logic                    oeop,
  output logic                    oval,
  output turbo_dec_pkg::addr_t    ofaddr,
  output turbo_dec_pkg::lextr_t   ofLextr,
  output logic                    ofdat,
  output turbo_dec_pkg::addr_t    obaddr,
  output turbo_dec_pkg::lextr_t   obLextr,
  output logic                    obdat,
  output logic                    odone,
  output turbo_dec_pkg::err_cnt_t oerr
);

  logic last_d;
  logic fterm_d;
  logic bterm_d;

  path_out_if f_out ();
  path_out_if b_out ();

  // --------------------------------------------------
  // forward and backward paths
  // --------------------------------------------------
  turbo_dec_path f_path (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .val  (ival), .first  (ifirst), .even    (ieven),
    .s_llr      (ifsLLR),
    .parity_llr (ifa0LLR),
    .lextr_in   (ifLextr),
    .pout       (f_out)
  );

  turbo_dec_path b_path (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .val  (ival), .first  (ifirst), .even    (ieven),
    .s_llr      (ibsLLR),
    .parity_llr (iba0LLR),
    .lextr_in   (ibLextr),
    .pout       (b_out)
  );

  // control and addresses ride beside the paths
  turbo_dec_ctrl_line u_ctrl (
    .iclk  (iclk), .ireset (ireset), .iclkena (iclkena),
    .sop   (isop),   .eop   (ieop),   .last    (ilast),
    .fterm (ifterm), .bterm (ibterm),
    .faddr (ifaddr), .baddr (ibaddr),
    .sop_d   (osop),    .eop_d   (oeop),    .last_d (last_d),
    .fterm_d (fterm_d), .bterm_d (bterm_d),
    .faddr_d (ofaddr),  .baddr_d (obaddr)
  );

  turbo_dec_out u_out (
    .iclk  (iclk), .ireset (ireset), .iclkena (iclkena),
    .f     (f_out), .b (b_out),
    .sop_d   (osop),    .eop_d   (oeop),    .last_d (last_d),
    .fterm_d (fterm_d), .bterm_d (bterm_d),
    .oval    (oval),    .odone   (odone),   .oerr   (oerr),
    .ofLextr (ofLextr), .ofdat   (ofdat),
    .obLextr (obLextr), .obdat   (obdat)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic iclk,
  output logic ireset
);

  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  // two cycles of reset, released on a falling edge
  initial begin
    ireset = 1'b1;
    repeat (2) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
  end

endmodule

`default_nettype wire

//--- turbo_dec_engine_tb.sv
`default_nettype none

module turbo_dec_engine_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_rows = 6;
  localparam int nbits  = 4;  // bits per block

  typedef turbo_dec_pkg::llr_t   [nbits-1:0] llr_vec_t;
  typedef turbo_dec_pkg::lextr_t [nbits-1:0] lextr_vec_t;

  // one block of stimulus with element k as bit k
  typedef struct packed {
    logic first, last, even, gate;  // gate = toggle iclkena
    logic [nbits-1:0] fterm;
    logic [nbits-1:0] bterm;
    llr_vec_t fs, fa;
    lextr_vec_t fl;
    llr_vec_t bs, ba;
    lextr_vec_t bl;
  } row_t;

  // expected output beat
  typedef struct packed {
    int row, due;  // due = enabled edge count at output
    logic sop, eop, last;
    turbo_dec_pkg::addr_t faddr, baddr;
    int flx, blx;
    logic fdat, bdat;
    int add;           // counted errors of this bit
  } exp_t;

  logic iclk, ireset, iclkena, ifirst, ilast, ieven, isop, ival, ieop;
  logic ifterm, ibterm, osop, oeop, oval, ofdat, obdat, odone;
  turbo_dec_pkg::addr_t    ifaddr, ibaddr, ofaddr, obaddr;
  turbo_dec_pkg::llr_t     ifsLLR, ifa0LLR, ibsLLR, iba0LLR;
  turbo_dec_pkg::lextr_t   ifLextr, ibLextr, ofLextr, obLextr;
  turbo_dec_pkg::err_cnt_t oerr;

  row_t  tbl [n_rows];
  string names [n_rows];
  exp_t  exp_q [$];
  int    en_cnt = 0;        // enabled rising edges so far
  logic  edge_en = 1'b0;    // last rising edge was enabled
  int    err_model = 0;     // model of oerr
  logic  done_next = 1'b0;  // odone expected at next sample
  int    done_cnt = 0;
  int    exp_done_cnt = 0;

  tb_clk_gen u_clk (.iclk(iclk), .ireset(ireset));

  turbo_dec_engine u_dut (.*);

  task automatic compare_value(string name, int expected, int actual);
    if (expected != actual) begin
      $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // ------------------------------------------------
  // reference model
  // ------------------------------------------------
  function automatic int ext_model(int s, int p, int lin, bit first, bit even);
    int apri;
    int apo;
    int e;
    int lim;
    apri = s + (first ? 0 : lin);  // extrinsic ignored on first pass
    apo  = apri + p;
    e    = (3 * (apo - apri)) >>> 2;  // floor of 3/4
    lim  = 1 << (turbo_dec_pkg::lextr_w - 1);
    if (e > lim - 1) begin
      e = lim - 1;
    end else if (e < -lim) begin
      e = -lim;
    end
    // sign flip against history zeroes it on odd passes
    if (!even && !first && lin != 0 && ((e < 0) != (lin < 0))) begin
      e = 0;
    end
    return e;
  endfunction

  function automatic llr_vec_t llr4(int b0, int b1, int b2, int b3);
    llr_vec_t v;
    v[0] = turbo_dec_pkg::llr_t'(b0);
    v[1] = turbo_dec_pkg::llr_t'(b1);
    v[2] = turbo_dec_pkg::llr_t'(b2);
    v[3] = turbo_dec_pkg::llr_t'(b3);
    return v;
  endfunction

  function automatic lextr_vec_t lextr4(int b0, int b1, int b2, int b3);
    lextr_vec_t v;
    v[0] = turbo_dec_pkg::lextr_t'(b0);
    v[1] = turbo_dec_pkg::lextr_t'(b1);
    v[2] = turbo_dec_pkg::lextr_t'(b2);
    v[3] = turbo_dec_pkg::lextr_t'(b3);
    return v;
  endfunction

  task automatic set_row(int r, string name, bit first, bit last, bit even, bit gate,
                         logic [nbits-1:0] fterm, logic [nbits-1:0] bterm,
                         llr_vec_t fs, llr_vec_t fa, lextr_vec_t fl,
                         llr_vec_t bs, llr_vec_t ba, lextr_vec_t bl);
    names[r] = name;
    tbl[r]   = {first, last, even, gate, fterm, bterm, fs, fa, fl, bs, ba, bl};
  endtask

  // ------------------------------------------------
  // stimulus table
  // ------------------------------------------------
  task automatic fill_table();
    // name, first, last, even, gate, fterm, bterm, fs, fa, fl, bs, ba, bl
    set_row(0, "first_pass", 1, 0, 1, 0, 4'b0000, 4'b0000,
            llr4(3, -4, 7, -1), llr4(5, -6, -8, 2), lextr4($urandom, $urandom, 9, -9),
            llr4(-2, 6, 0, -7), llr4(-3, 9, 1, 4), lextr4(-20, $urandom, 31, $urandom));
    set_row(1, "even_pass", 0, 0, 1, 0, 4'b0000, 4'b0000,
            llr4(2, -3, 5, -6), llr4(-9, 7, 3, -2), lextr4(12, -10, -4, 8),
            llr4(4, -1, -5, 3), llr4(6, -7, -12, 10), lextr4(-8, 9, 11, -6));
    set_row(2, "odd_pass", 0, 0, 0, 0, 4'b0000, 4'b0000,
            llr4(6, -2, 1, -4), llr4(8, -8, 4, 6), lextr4(-5, -3, 0, 7),
            llr4(-3, 5, 2, 0), llr4(-10, 11, -1, 1), lextr4(9, 14, -2, -4));
    set_row(3, "parity_extremes", 1, 0, 0, 0, 4'b0000, 4'b0000,
            llr4(15, -16, 0, -1), llr4(-16, 15, -16, 15), lextr4(0, 0, 0, 0),
            llr4(-16, 15, 7, -7), llr4(15, -16, 15, -16), lextr4(0, 0, 0, 0));
    set_row(4, "clkena_gate", 0, 1, 0, 1, 4'b1000, 4'b0001,  // random llrs
            llr4($urandom, $urandom, $urandom, $urandom),
            llr4($urandom, $urandom, $urandom, $urandom),
            lextr4($urandom, $urandom, $urandom, $urandom),
            llr4($urandom, $urandom, $urandom, $urandom),
            llr4($urandom, $urandom, $urandom, $urandom),
            lextr4($urandom, $urandom, $urandom, $urandom));
    set_row(5, "last_block", 0, 1, 1, 0, 4'b0101, 4'b0010,
            llr4(-3, -2, 4, -1), llr4(10, 9, -12, 3), lextr4(1, 2, 3, 0),
            llr4(5, -4, 2, -6), llr4(-9, 8, -5, 9), lextr4(0, 0, 0, 0));
  endtask

  task automatic idle_inputs();
    iclkena = 1'b1;
    {ifirst, ilast, ieven, isop, ival, ieop, ifterm, ibterm} = '0;
    {ifaddr, ibaddr, ifsLLR, ifa0LLR, ibsLLR, iba0LLR, ifLextr, ibLextr} = '0;
  endtask

  // called on a falling edge and holds each bit until an enabled edge takes it
  task automatic drive_row(int r);
    row_t t;
    exp_t e;
    bit   taken;
    int   fsi, fai, fli, bsi, bai, bli;
    t = tbl[r];
    for (int k = 0; k < nbits; k++) begin
      {ifirst, ilast, ieven, ival} = {t.first, t.last, t.even, 1'b1};
      isop    = (k == 0);
      ieop    = (k == nbits - 1);
      ifterm  = t.fterm[k];
      ibterm  = t.bterm[k];
      ifaddr  = turbo_dec_pkg::addr_t'(r * 16 + k);
      ibaddr  = turbo_dec_pkg::addr_t'(r * 16 + nbits - 1 - k);  // backward order
      ifsLLR  = t.fs[k];
      ifa0LLR = t.fa[k];
      ifLextr = t.fl[k];
      ibsLLR  = t.bs[k];
      iba0LLR = t.ba[k];
      ibLextr = t.bl[k];
      taken   = 1'b0;
      while (!taken) begin
        iclkena = t.gate ? 1'($urandom_range(1, 0)) : 1'b1;
        taken   = iclkena;
        @(negedge iclk);
      end
      fsi = int'(signed'(t.fs[k]));
      fai = int'(signed'(t.fa[k]));
      fli = int'(signed'(t.fl[k]));
      bsi = int'(signed'(t.bs[k]));
      bai = int'(signed'(t.ba[k]));
      bli = int'(signed'(t.bl[k]));
      e.row   = r;
      // en_cnt already counts the edge that took the bit
      e.due   = en_cnt + turbo_dec_pkg::engine_delay - 1;
      e.sop   = isop;
      e.eop   = ieop;
      e.last  = t.last;
      e.faddr = ifaddr;
      e.baddr = ibaddr;
      e.flx   = ext_model(fsi, fai, fli, t.first, t.even);
      e.blx   = ext_model(bsi, bai, bli, t.first, t.even);
      e.fdat  = (fsi + (t.first ? 0 : fli) + fai) < 0;  // sign of a posteriori
      e.bdat  = (bsi + (t.first ? 0 : bli) + bai) < 0;
      e.add   = int'((e.fdat != (fsi < 0)) && !t.fterm[k]) +
                int'((e.bdat != (bsi < 0)) && !t.bterm[k]);
      exp_q.push_back(e);
    end
    if (t.last) begin
      exp_done_cnt++;
    end
    idle_inputs();
    repeat (2) @(negedge iclk);  // gap between blocks
  endtask

  // ------------------------------------------------
  // monitor sampling outputs on the falling edge
  // ------------------------------------------------
  always @(posedge iclk) begin
    edge_en <= iclkena;
    if (iclkena) begin
      en_cnt <= en_cnt + 1;
    end
  end

  always @(negedge iclk) begin : monitor
    exp_t  e;
    string nm;
    logic  due;
    if (edge_en) begin  // one sample per enabled edge
      due = (exp_q.size() > 0) && (exp_q[0].due == en_cnt);
      nm  = (exp_q.size() > 0) ? names[exp_q[0].row] : "idle";
      compare_value({nm, "/oval"}, int'(due), int'(oval));
      compare_value({nm, "/odone"}, int'(done_next), int'(odone));
      compare_value({nm, "/oerr"}, err_model, int'(oerr));
      if (odone) begin
        done_cnt++;
      end
      done_next = 1'b0;
      if (oval) begin
        e = exp_q.pop_front();
        compare_value({nm, "/osop"}, int'(e.sop), int'(osop));
        compare_value({nm, "/oeop"}, int'(e.eop), int'(oeop));
        compare_value({nm, "/ofaddr"}, int'(e.faddr), int'(ofaddr));
        compare_value({nm, "/obaddr"}, int'(e.baddr), int'(obaddr));
        compare_value({nm, "/ofLextr"}, e.flx, int'(ofLextr));
        compare_value({nm, "/obLextr"}, e.blx, int'(obLextr));
        compare_value({nm, "/ofdat"}, int'(e.fdat), int'(ofdat));
        compare_value({nm, "/obdat"}, int'(e.bdat), int'(obdat));
        err_model = (e.sop ? 0 : err_model) + e.add;  // seen one sample later
        done_next = e.eop & e.last;
      end
    end
  end

  // ------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------
  initial begin : main
    void'($urandom(32'hdef8_533f));
    idle_inputs();
    fill_table();
    @(negedge ireset);
    @(negedge iclk);
    for (int r = 0; r < n_rows; r++) begin
      drive_row(r);
    end
    while (exp_q.size() != 0) begin
      @(negedge iclk);
    end
    repeat (4) @(negedge iclk);  // let odone and oerr settle
    compare_value("all/odone count", exp_done_cnt, done_cnt);
    $display("Testbench passed");
    $finish;
  end

  initial begin : watchdog
    repeat (n_rows * nbits * 20) @(posedge iclk);
    $display("timeout, not all expected results came out of the DUT");
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- sim.f
turbo_dec_pkg.sv
path_out_if.sv
turbo_dec_bmc.sv
turbo_dec_lextr.sv
turbo_dec_path.sv
turbo_dec_ctrl_line.sv
turbo_dec_out.sv
turbo_dec_engine.sv
tb_clk_gen.sv
turbo_dec_engine_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = turbo_dec_engine_tb
FLIST     = sim.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
PASS_MSG  = Testbench passed
SRCS      = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD)
